//--- project.f
+incdir+hdl
hdl/bpred_pkg.sv
hdl/branch_target_buffer.sv
hdl/gshare_predictor.sv
hdl/branch_predictor.sv
sim/tb_branch_predictor.sv

//--- Makefile
# Verilator build and run of the branch predictor regression.
TOP := tb_branch_predictor

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the regression, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_branch_predictor.sv
// Self-checking testbench for the branch predictor; compiled from project.f and run by the Makefile.
`timescale 1ns/10ps
`default_nettype none

module tb_branch_predictor;

    typedef struct packed {
        logic        hit;
        logic        taken;
        logic [31:0] target;
        logic [4:0]  idx;
    } pred_t;

    logic               clk;
    logic               arst_n_i;
    logic [31:0]        fetch_pc;
    logic               pred_hit;
    logic               pred_taken;
    logic [31:0]        pred_target;
    logic [4:0]         pht_index;
    logic               upd_valid;
    logic [31:0]        upd_pc;
    bpred_pkg::opcode_e upd_op;
    logic               upd_taken;
    logic [31:0]        upd_target;
    logic [4:0]         upd_pht_index;
    logic               ghr_clear;

    // Reference model state.
    logic        m_valid  [0:31];
    logic [24:0] m_tag    [0:31];
    logic        m_jump   [0:31];
    logic [31:0] m_target [0:31];
    logic [1:0]  m_pht    [0:31];
    logic [4:0]  m_ghr;

    logic [31:0] rng;
    logic        cmp_en;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    branch_predictor dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .fetch_pc_i      (fetch_pc),
        .pred_hit_o      (pred_hit),
        .pred_taken_o    (pred_taken),
        .pred_target_o   (pred_target),
        .pht_index_o     (pht_index),
        .upd_valid_i     (upd_valid),
        .upd_pc_i        (upd_pc),
        .upd_op_i        (upd_op),
        .upd_taken_i     (upd_taken),
        .upd_target_i    (upd_target),
        .upd_pht_index_i (upd_pht_index),
        .ghr_clear_i     (ghr_clear)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected lookup result from the model state.
    function automatic pred_t predict_ref(input logic [31:0] pc);
        pred_t      p;
        logic [4:0] i;
        i     = pc[6:2];
        p     = '0;
        p.idx = i ^ m_ghr;
        if (m_valid[i] && m_tag[i] == pc[31:7]) begin
            p.hit    = 1'b1;
            p.target = m_target[i];
            p.taken  = m_jump[i] ? 1'b1 : m_pht[p.idx][1];
        end
        return p;
    endfunction

    // Model update, same edge as the DUT.
    always @(posedge clk or negedge arst_n_i) begin
        logic is_cf;
        logic is_br;
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                m_valid[i] = 1'b0;
                m_pht[i]   = 2'b01;
            end
            m_ghr = '0;
        end else begin
            is_br = (upd_op == bpred_pkg::OP_BRANCH);
            is_cf = is_br || upd_op == bpred_pkg::OP_JAL || upd_op == bpred_pkg::OP_JALR;
            if (upd_valid && upd_taken && is_cf) begin
                m_valid[upd_pc[6:2]]  = 1'b1;
                m_tag[upd_pc[6:2]]    = upd_pc[31:7];
                m_jump[upd_pc[6:2]]   = !is_br;
                m_target[upd_pc[6:2]] = upd_target;
            end
            if (upd_valid && is_br) begin
                if (upd_taken && m_pht[upd_pht_index] != 2'b11) begin
                    m_pht[upd_pht_index] = m_pht[upd_pht_index] + 2'd1;
                end else if (!upd_taken && m_pht[upd_pht_index] != 2'b00) begin
                    m_pht[upd_pht_index] = m_pht[upd_pht_index] - 2'd1;
                end
            end
            if (ghr_clear) begin
                m_ghr = '0;
            end else if (upd_valid && is_br) begin
                m_ghr = {m_ghr[3:0], upd_taken};
            end
        end
    end

    task automatic check_outputs(input pred_t exp, input string what);
        assert (pred_hit === exp.hit && pred_taken === exp.taken &&
                pred_target === exp.target && pht_index === exp.idx) else begin
            $display("mismatch at %0t: %s pc %h (got/exp) hit %0b/%0b taken %0b/%0b",
                     $time, what, fetch_pc, pred_hit, exp.hit, pred_taken, exp.taken);
            $display("    target %h/%h idx %0d/%0d", pred_target, exp.target,
                     pht_index, exp.idx);
            errors++;
        end
    endtask

    // Mid-cycle compare against the model.
    always @(negedge clk) begin
        if (cmp_en) begin
            check_outputs(predict_ref(fetch_pc), "model");
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic pred_t make_pred(input logic hit, input logic taken,
                                        input logic [31:0] target, input logic [4:0] idx);
        pred_t p;
        p.hit    = hit;
        p.taken  = taken;
        p.target = target;
        p.idx    = idx;
        return p;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_update(input logic [31:0] pc, input bpred_pkg::opcode_e op,
                                input logic taken, input logic [31:0] target,
                                input logic [4:0] idx, input logic clr);
        step();
        upd_valid     = 1'b1;
        upd_pc        = pc;
        upd_op        = op;
        upd_taken     = taken;
        upd_target    = target;
        upd_pht_index = idx;
        ghr_clear     = clr;
    endtask

    task automatic probe(input logic [31:0] pc);
        step();
        upd_valid = 1'b0;
        fetch_pc  = pc;
        @(negedge clk);
    endtask

    task automatic lookup_check(input logic [31:0] pc, input pred_t exp, input string what);
        probe(pc);
        check_outputs(exp, what);
    endtask

    task automatic wait_for_hit(input logic [31:0] pc, input int limit, output int cycles);
        cycles = 0;
        probe(pc);
        while (!pred_hit && cycles < limit) begin
            cycles++;
            probe(pc);
        end
        if (!pred_hit) begin
            $display("timeout: no BTB hit at pc %h within %0d cycles", pc, limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        #1; // Let the mid-cycle compare settle.
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    function automatic logic [31:0] pick_pc(input logic [2:0] sel);
        return {sel[2] ? 25'h3 : 25'h5, 3'b000, sel[1:0], 2'b00}; // Two tags alias.
    endfunction

    function automatic bpred_pkg::opcode_e pick_op(input logic [1:0] sel);
        case (sel)
            2'd0:    return bpred_pkg::OP_BRANCH;
            2'd1:    return bpred_pkg::OP_JAL;
            2'd2:    return bpred_pkg::OP_JALR;
            default: return bpred_pkg::opcode_e'(7'b0110011); // ALU op.
        endcase
    endfunction

    task automatic train_and_check(input logic taken, input logic exp_hit,
                                   input logic exp_taken, input string what);
        apply_update(32'h0000_4010, bpred_pkg::OP_BRANCH, taken, 32'h0000_5000, 5'd4, 1'b1);
        lookup_check(32'h0000_4010,
                     make_pred(exp_hit, exp_taken, exp_hit ? 32'h0000_5000 : 32'h0, 5'd4),
                     what);
    endtask

    initial begin
        int         errs;
        int         cycles;
        logic [4:0] exp_ghr;
        logic [31:0] pc;
        logic [4:0] seq;
        arst_n_i      = 1'b0;
        fetch_pc      = '0;
        upd_valid     = 1'b0;
        upd_pc        = '0;
        upd_op        = bpred_pkg::OP_BRANCH;
        upd_taken     = 1'b0;
        upd_target    = '0;
        upd_pht_index = '0;
        ghr_clear     = 1'b0;
        rng           = 32'haa52;
        cmp_en        = 1'b0;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        #2;
        arst_n_i = 1'b1;
        cmp_en   = 1'b1;

        errs = errors;
        for (int k = 0; k < 4; k++) begin
            pc = 32'h0000_0100 + k * 36;
            lookup_check(pc, make_pred(1'b0, 1'b0, 32'h0, pc[6:2]), "reset lookup");
        end
        finish_test("reset_state", errs);

        errs = errors;
        apply_update(32'h0000_1044, bpred_pkg::OP_JAL, 1'b1, 32'h0000_2000, 5'd0, 1'b0);
        wait_for_hit(32'h0000_1044, 4, cycles);
        check_value(cycles, 0, "cycles until install visible");
        check_outputs(make_pred(1'b1, 1'b1, 32'h0000_2000, 5'h11), "jal hit");
        lookup_check(32'h0000_2044, make_pred(1'b0, 1'b0, 32'h0, 5'h11), "tag alias miss");
        finish_test("jump_install", errs);

        errs = errors;
        train_and_check(1'b0, 1'b0, 1'b0, "not taken, no install"); // Counter 00.
        train_and_check(1'b1, 1'b1, 1'b0, "installed, counter 01");
        train_and_check(1'b1, 1'b1, 1'b1, "counter 10");
        train_and_check(1'b1, 1'b1, 1'b1, "counter 11");
        train_and_check(1'b1, 1'b1, 1'b1, "counter saturated");
        train_and_check(1'b0, 1'b1, 1'b1, "counter back to 10");
        train_and_check(1'b0, 1'b1, 1'b0, "counter back to 01");
        finish_test("counters", errs);

        errs = errors;
        exp_ghr = '0;
        seq     = 5'b01101;
        for (int k = 0; k < 5; k++) begin
            pc = 32'h0000_3000 + k * 8;
            apply_update(pc, bpred_pkg::OP_BRANCH, seq[k], 32'h0000_6000,
                         pc[6:2] ^ exp_ghr, 1'b0);
            exp_ghr = {exp_ghr[3:0], seq[k]};
            probe(pc);
            check_value({27'd0, pht_index}, {27'd0, pc[6:2] ^ exp_ghr}, "history index");
            if (!seq[k]) begin
                check_value({31'd0, pred_hit}, 32'd0, "not-taken branch installed");
            end
        end
        apply_update(32'h0000_3000, bpred_pkg::OP_BRANCH, 1'b1, 32'h0000_6000, 5'd0, 1'b1);
        exp_ghr = '0; // Clear wins over the shift.
        probe(32'h0000_3008);
        check_value({27'd0, pht_index}, 32'd2, "index after clear");
        finish_test("history", errs);

        errs = errors;
        for (int n = 0; n < 4000; n++) begin
            step();
            rng           = xorshift32(rng);
            fetch_pc      = pick_pc(rng[2:0]);
            upd_valid     = rng[3];
            upd_pc        = pick_pc(rng[6:4]);
            upd_op        = pick_op(rng[8:7]);
            upd_taken     = rng[9];
            ghr_clear     = (rng[14:10] == 5'd0);
            upd_pht_index = rng[15] ? (upd_pc[6:2] ^ m_ghr) : rng[20:16];
            rng           = xorshift32(rng);
            upd_target    = {rng[31:2], 2'b00};
        end
        step();
        upd_valid = 1'b0;
        ghr_clear = 1'b0;
        @(negedge clk);
        finish_test("random", errs);

        cmp_en = 1'b0;
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
// Fetch-stage branch predictor top that merges BTB hit and kind with the gshare direction.
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module branch_predictor (
    input  wire logic                         clk,
    input  wire logic                         arst_n_i,

    // Fetch side.
    input  wire logic [`BPRED_XLEN-1:0]       fetch_pc_i,
    output logic                              pred_hit_o,
    output logic                              pred_taken_o,
    output logic [`BPRED_XLEN-1:0]            pred_target_o,
    output logic [`BPRED_GHR_BITS-1:0]        pht_index_o,

    // Execute side.
    input  wire logic                         upd_valid_i,
    input  wire logic [`BPRED_XLEN-1:0]       upd_pc_i,
    input  wire bpred_pkg::opcode_e           upd_op_i,
    input  wire logic                         upd_taken_i,
    input  wire logic [`BPRED_XLEN-1:0]       upd_target_i,
    input  wire logic [`BPRED_GHR_BITS-1:0]   upd_pht_index_i,
    input  wire logic                         ghr_clear_i
);

    logic                  btb_hit;
    bpred_pkg::btb_kind_e  btb_kind;
    logic                  dir_taken;

    branch_target_buffer #(
        .NUM_ENTRIES (`BPRED_BTB_ENTRIES)
    ) btb0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .lookup_pc_i  (fetch_pc_i),
        .hit_o        (btb_hit),
        .kind_o       (btb_kind),
        .target_o     (pred_target_o), // Already zero on a miss.
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_op_i     (upd_op_i),
        .upd_taken_i  (upd_taken_i),
        .upd_target_i (upd_target_i)
    );

    gshare_predictor #(
        .GHR_BITS (`BPRED_GHR_BITS)
    ) gshare0 (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .lookup_pc_i     (fetch_pc_i),
        .pht_index_o     (pht_index_o),
        .predict_taken_o (dir_taken),
        .upd_valid_i     (upd_valid_i),
        .upd_op_i        (upd_op_i),
        .upd_taken_i     (upd_taken_i),
        .upd_pht_index_i (upd_pht_index_i),
        .ghr_clear_i     (ghr_clear_i)
    );

    assign pred_hit_o = btb_hit;

    // Jumps always go, branches follow the counter, misses fall through.
    assign pred_taken_o = btb_hit &&
                          ((btb_kind == bpred_pkg::KIND_JUMP) || dir_taken);

endmodule

`default_nettype wire

//--- hdl/gshare_predictor.sv
// Gshare direction predictor indexing 2-bit counters by global history XOR PC, used by the top.
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module gshare_predictor #(
    parameter int GHR_BITS = `BPRED_GHR_BITS,
    localparam int XLEN = `BPRED_XLEN
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,

    // Lookup from fetch.
    input  wire logic [XLEN-1:0]       lookup_pc_i,
    output logic [GHR_BITS-1:0]        pht_index_o,
    output logic                       predict_taken_o,

    // Resolved instruction from execute.
    input  wire logic                  upd_valid_i,
    input  wire bpred_pkg::opcode_e    upd_op_i,
    input  wire logic                  upd_taken_i,
    input  wire logic [GHR_BITS-1:0]   upd_pht_index_i,

    // Pipeline flush.
    input  wire logic                  ghr_clear_i
);

    localparam int PHT_ENTRIES = 1 << GHR_BITS;
    localparam logic [1:0] CTR_RESET = 2'b01; // Weakly not taken.
    localparam logic [1:0] CTR_MAX   = 2'b11;
    localparam logic [1:0] CTR_MIN   = 2'b00;

    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [0:PHT_ENTRIES-1];

    logic                train;
    logic [1:0]          upd_ctr;
    logic [1:0]          upd_ctr_next;

    assign pht_index_o     = lookup_pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign predict_taken_o = pht_q[pht_index_o][1]; // Upper bit gives direction.

    // Only conditional branches train counters and history.
    assign train = upd_valid_i && (upd_op_i == bpred_pkg::OP_BRANCH);

    assign upd_ctr = pht_q[upd_pht_index_i];

    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd_taken_i) begin
            if (upd_ctr != CTR_MAX) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != CTR_MIN) begin
                upd_ctr_next = upd_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_RESET;
            end
        end else if (train) begin
            pht_q[upd_pht_index_i] <= upd_ctr_next;
        end
    end

    // History register; flush beats a shift in the same cycle.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0;
        end else if (train) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], upd_taken_i}; // Newest outcome in bit 0.
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_target_buffer.sv
// Direct-mapped tagged BTB with combinational lookup and single-edge install from execute.
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module branch_target_buffer #(
    parameter int NUM_ENTRIES = `BPRED_BTB_ENTRIES,
    localparam int XLEN = `BPRED_XLEN
) (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,

    // Lookup from fetch.
    input  wire logic [XLEN-1:0]       lookup_pc_i,
    output logic                       hit_o,
    output bpred_pkg::btb_kind_e       kind_o,
    output logic [XLEN-1:0]            target_o,

    // Resolved instruction from execute.
    input  wire logic                  upd_valid_i,
    input  wire logic [XLEN-1:0]       upd_pc_i,
    input  wire bpred_pkg::opcode_e    upd_op_i,
    input  wire logic                  upd_taken_i,
    input  wire logic [XLEN-1:0]       upd_target_i
);

    localparam int IDX_BITS = $clog2(NUM_ENTRIES);
    localparam int TAG_BITS = XLEN - IDX_BITS - 2;

    // Per-entry state.
    logic [NUM_ENTRIES-1:0]  valid_q;
    logic [TAG_BITS-1:0]     tag_q    [0:NUM_ENTRIES-1];
    bpred_pkg::btb_kind_e    kind_q   [0:NUM_ENTRIES-1];
    logic [XLEN-1:0]         target_q [0:NUM_ENTRIES-1];

    // Lookup fields.
    logic [IDX_BITS-1:0]     rd_idx;
    logic [TAG_BITS-1:0]     rd_tag;
    logic                    rd_match;

    // Install fields.
    logic [IDX_BITS-1:0]     wr_idx;
    logic [TAG_BITS-1:0]     wr_tag;
    logic                    wr_is_cf;
    logic                    wr_en;
    bpred_pkg::btb_kind_e    wr_kind;

    assign rd_idx = lookup_pc_i[IDX_BITS+1:2]; // Word-aligned PCs.
    assign rd_tag = lookup_pc_i[XLEN-1:IDX_BITS+2];

    assign rd_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    always_comb begin
        if (rd_match) begin
            hit_o    = 1'b1;
            kind_o   = kind_q[rd_idx];
            target_o = target_q[rd_idx];
        end else begin
            hit_o    = 1'b0;
            kind_o   = bpred_pkg::KIND_BRANCH;
            target_o = '0; // Miss returns a zero target.
        end
    end

    assign wr_idx = upd_pc_i[IDX_BITS+1:2];
    assign wr_tag = upd_pc_i[XLEN-1:IDX_BITS+2];

    always_comb begin
        case (upd_op_i)
            bpred_pkg::OP_BRANCH,
            bpred_pkg::OP_JAL,
            bpred_pkg::OP_JALR: wr_is_cf = 1'b1;
            default:            wr_is_cf = 1'b0;
        endcase
    end

    // Only taken control flow is worth a BTB slot.
    assign wr_en   = upd_valid_i && upd_taken_i && wr_is_cf;
    assign wr_kind = (upd_op_i == bpred_pkg::OP_BRANCH) ? bpred_pkg::KIND_BRANCH
                                                        : bpred_pkg::KIND_JUMP;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            kind_q[wr_idx]   <= wr_kind;
            target_q[wr_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bpred_pkg.sv
// Shared opcode and BTB entry-kind types, referenced by scoped name from the predictor modules.
`default_nettype none

package bpred_pkg;

    // RISC-V major opcodes that matter to the predictor.
    // Any other 7-bit value reaching the update port is treated as not control flow.
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // Conditional branches.
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // Kind of control transfer held in a BTB entry.
    typedef enum logic {
        KIND_BRANCH = 1'b0, // Direction comes from the PHT.
        KIND_JUMP   = 1'b1  // Always taken.
    } btb_kind_e;

endpackage

`default_nettype wire

//--- hdl/bpred_defines.svh
// Size and width macros for the branch predictor, included by every RTL module that needs them.
`ifndef BPRED_DEFINES_SVH
`define BPRED_DEFINES_SVH

// Width of fetch PCs and branch targets.
`define BPRED_XLEN 32

// Direct-mapped BTB depth; must be a power of two.
`define BPRED_BTB_ENTRIES 32

// Global history length, also the PHT index width.
// The pattern table holds 2**BPRED_GHR_BITS counters and needs at least two history bits.
`define BPRED_GHR_BITS 5

`endif
